//--- common/cpu_pkg.sv
package cpu_pkg;

  localparam int data_size = 32;
  localparam int mem_size  = 10;
  localparam int addr_size = 5;
  // data memory depth in words, as an address width
  localparam int dmem_size = 8;

  // major opcode, instr[30:25]
  typedef enum logic [5:0] {
    type_basic = 6'b100000,
    addi       = 6'b101000,
    ori        = 6'b101100,
    xori       = 6'b101011,
    lwi        = 6'b000010,
    swi        = 6'b001010,
    movi       = 6'b100010,
    type_ls    = 6'b011100
  } opcode_e;

  // basic type sub opcode, instr[4:0]
  typedef enum logic [4:0] {
    op_add   = 5'b00000,
    op_sub   = 5'b00001,
    op_and   = 5'b00010,
    op_xor   = 5'b00011,
    op_or    = 5'b00100,
    op_slli  = 5'b01000,
    op_srli  = 5'b01001,
    op_rotri = 5'b01011
  } sub_op_e;

  // load/store type sub opcode, instr[7:0]
  typedef enum logic [7:0] {
    ls_lw = 8'b00000010,
    ls_sw = 8'b00001010
  } ls_op_e;

  typedef enum logic [1:0] {
    stop_state  = 2'b00,
    fetch_state = 2'b01,
    exe_state   = 2'b10,
    write_state = 2'b11
  } state_e;

  typedef enum logic [1:0] {
    imm5_ze  = 2'b00,
    imm15_se = 2'b01,
    imm15_ze = 2'b10,
    imm20_se = 2'b11
  } imm_sel_e;

  typedef struct packed {
    opcode_e                opcode;
    sub_op_e                sub_op5;
    ls_op_e                 sub_op8;
    logic [1:0]             sv;
    logic [4:0]             imm5;
    logic [14:0]            imm15;
    logic [19:0]            imm20;
    logic [addr_size-1:0]   read_address1;
    logic [addr_size-1:0]   read_address2;
    logic [addr_size-1:0]   write_address;
  } fields_t;

  typedef struct packed {
    logic     reg_read;
    logic     alu_execute;
    logic     reg_write;
    logic     dm_enable;
    logic     dm_write;
    imm_sel_e imm_sel;
    logic     use_imm;
    logic     wb_from_mem;
  } ctrl_t;

  typedef struct packed {
    logic [mem_size-1:0]  pc;
    logic                 reg_write;
    logic [addr_size-1:0] write_address;
    logic [data_size-1:0] write_data;
    logic                 store;
    logic [dmem_size-1:0] store_address;
    logic [data_size-1:0] store_data;
  } commit_t;

endpackage

//--- controller/ir_controller.sv
`timescale 1ns/100ps

module ir_controller (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         run,
  input  logic [cpu_pkg::mem_size-1:0] pc,
  input  logic [cpu_pkg::data_size-1:0] instr,
  output cpu_pkg::fields_t             fields,
  output cpu_pkg::ctrl_t               ctrl,
  output logic                         pc_advance,
  output logic                         commit_valid,
  output logic [cpu_pkg::mem_size-1:0] commit_pc
);
  import cpu_pkg::*;

  state_e               state;
  state_e               next_state;
  logic [data_size-1:0] ir;
  logic [mem_size-1:0]  ir_pc;
  logic                 is_nop;
  logic                 is_store;
  logic                 is_load;
  logic                 is_shift;

  // sequencer
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= stop_state;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    case (state)
      stop_state:  next_state = run ? fetch_state : stop_state;
      fetch_state: next_state = exe_state;
      exe_state:   next_state = write_state;
      default:     next_state = stop_state;
    endcase
  end

  // instruction register and its pc, taken at the end of fetch
  always_ff @(posedge clock) begin
    if (state == fetch_state) begin
      ir    <= instr;
      ir_pc <= pc;
    end
  end

  // field split
  always_comb begin
    fields.opcode        = opcode_e'(ir[30:25]);
    fields.sub_op5       = sub_op_e'(ir[4:0]);
    fields.sub_op8       = ls_op_e'(ir[7:0]);
    fields.sv            = ir[9:8];
    fields.imm5          = ir[14:10];
    fields.imm15         = ir[14:0];
    fields.imm20         = ir[19:0];
    fields.read_address1 = ir[19:15];
    fields.write_address = ir[24:20];
    // store data comes out of port 2, so stores read rt there
    fields.read_address2 = is_store ? ir[24:20] : ir[14:10];
  end

  assign is_nop   = fields.opcode == type_basic && fields.sub_op5 == op_srli &&
                    fields.imm5 == 5'd0;
  assign is_store = fields.opcode == swi ||
                    (fields.opcode == type_ls && fields.sub_op8 == ls_sw);
  assign is_load  = fields.opcode == lwi ||
                    (fields.opcode == type_ls && fields.sub_op8 == ls_lw);
  assign is_shift = fields.sub_op5 == op_srli || fields.sub_op5 == op_slli ||
                    fields.sub_op5 == op_rotri;

  always_comb begin
    ctrl             = '0;
    ctrl.imm_sel     = imm5_ze;
    ctrl.reg_read    = state == fetch_state;
    ctrl.alu_execute = state == exe_state;
    ctrl.wb_from_mem = is_load;

    if (state == write_state && !is_nop) begin
      if (is_store) begin
        ctrl.dm_enable = 1'b1;
        ctrl.dm_write  = 1'b1;
      end else begin
        ctrl.reg_write = 1'b1;
        ctrl.dm_enable = is_load;
      end
    end

    case (fields.opcode)
      type_basic: ctrl.use_imm = is_shift;
      addi: begin
        ctrl.imm_sel = imm15_se;
        ctrl.use_imm = 1'b1;
      end
      ori, xori, lwi, swi: begin
        ctrl.imm_sel = imm15_ze;
        ctrl.use_imm = 1'b1;
      end
      movi: begin
        ctrl.imm_sel = imm20_se;
        ctrl.use_imm = 1'b1;
      end
      default: ctrl.use_imm = 1'b0;
    endcase
  end

  assign pc_advance   = state == write_state;
  assign commit_valid = state == write_state;
  assign commit_pc    = ir_pc;

  // a register write and a store never share a commit
  assert property (@(posedge clock) disable iff (reset)
    !(ctrl.reg_write && ctrl.dm_write));

  // pc moves only on the edge that ends write
  assert property (@(posedge clock) disable iff (reset)
    !$stable(pc) |-> $past(state) == write_state);

  // read, execute and commit follow each other with no gap
  assert property (@(posedge clock) disable iff (reset)
    ctrl.reg_read |=> ctrl.alu_execute ##1 pc_advance);

endmodule

//--- datapath/alu.sv
`timescale 1ns/100ps

module alu (
  input  cpu_pkg::fields_t               fields,
  input  cpu_pkg::ctrl_t                 ctrl,
  input  logic [cpu_pkg::data_size-1:0]  read_data1,
  input  logic [cpu_pkg::data_size-1:0]  read_data2,
  input  logic [cpu_pkg::data_size-1:0]  dm_read_data,
  output logic [cpu_pkg::dmem_size-1:0]  dm_address,
  output logic [cpu_pkg::data_size-1:0]  dm_write_data,
  output logic [cpu_pkg::data_size-1:0]  result
);
  import cpu_pkg::*;

  logic [data_size-1:0]   imm;
  logic [data_size-1:0]   operand_b;
  logic [4:0]             shamt;
  logic [2*data_size-1:0] rot_pair;
  logic [data_size-1:0]   alu_out;
  logic [data_size-1:0]   eff_address;

  always_comb begin
    case (ctrl.imm_sel)
      imm5_ze:  imm = {27'd0, fields.imm5};
      imm15_se: imm = {{17{fields.imm15[14]}}, fields.imm15};
      imm15_ze: imm = {17'd0, fields.imm15};
      default:  imm = {{12{fields.imm20[19]}}, fields.imm20};
    endcase
  end

  assign operand_b = ctrl.use_imm ? imm : read_data2;
  assign shamt     = operand_b[4:0];
  // rotate right through a doubled copy
  assign rot_pair  = {read_data1, read_data1} >> shamt;

  always_comb begin
    case (fields.opcode)
      type_basic: begin
        case (fields.sub_op5)
          op_add:   alu_out = read_data1 + operand_b;
          op_sub:   alu_out = read_data1 - operand_b;
          op_and:   alu_out = read_data1 & operand_b;
          op_or:    alu_out = read_data1 | operand_b;
          op_xor:   alu_out = read_data1 ^ operand_b;
          op_slli:  alu_out = read_data1 << shamt;
          op_srli:  alu_out = read_data1 >> shamt;
          op_rotri: alu_out = rot_pair[data_size-1:0];
          default:  alu_out = '0;
        endcase
      end
      addi:    alu_out = read_data1 + operand_b;
      ori:     alu_out = read_data1 | operand_b;
      xori:    alu_out = read_data1 ^ operand_b;
      movi:    alu_out = operand_b;
      default: alu_out = '0;
    endcase
  end

  // lw and sw scale the port 2 value by sv, lwi and swi add imm15
  assign eff_address = (fields.opcode == type_ls) ?
                       read_data1 + (read_data2 << fields.sv) :
                       read_data1 + operand_b;

  assign dm_address    = eff_address[dmem_size-1:0];
  assign dm_write_data = read_data2;
  assign result        = ctrl.wb_from_mem ? dm_read_data : alu_out;

endmodule

//--- datapath/register_file.sv
`timescale 1ns/100ps

module register_file (
  input  logic                          clock,
  input  logic                          reset,
  input  cpu_pkg::fields_t              fields,
  input  cpu_pkg::ctrl_t                ctrl,
  input  logic [cpu_pkg::data_size-1:0] write_data,
  output logic [cpu_pkg::data_size-1:0] read_data1,
  output logic [cpu_pkg::data_size-1:0] read_data2
);
  import cpu_pkg::*;

  logic [data_size-1:0] regs [2**addr_size];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 2**addr_size; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.reg_write) begin
      regs[fields.write_address] <= write_data;
    end
  end

  // both reads see the current contents, no bypass
  assign read_data1 = regs[fields.read_address1];
  assign read_data2 = regs[fields.read_address2];

endmodule

//--- hdl/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          load_enable,
  input  logic [cpu_pkg::mem_size-1:0]  load_address,
  input  logic [cpu_pkg::data_size-1:0] load_instr,
  input  logic                          pc_advance,
  output logic [cpu_pkg::mem_size-1:0]  pc,
  output logic [cpu_pkg::data_size-1:0] instr
);
  import cpu_pkg::*;

  logic [data_size-1:0] imem [2**mem_size];

  // pc wraps at the top of instruction memory
  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
    end else if (pc_advance) begin
      pc <= pc + 1'b1;
    end
  end

  // load port
  always_ff @(posedge clock) begin
    if (load_enable) begin
      imem[load_address] <= load_instr;
    end
  end

  assign instr = imem[pc];

endmodule

//--- hdl/data_mem.sv
`timescale 1ns/100ps

module data_mem (
  input  logic                          clock,
  input  logic                          reset,
  input  cpu_pkg::ctrl_t                ctrl,
  input  logic [cpu_pkg::dmem_size-1:0] address,
  input  logic [cpu_pkg::data_size-1:0] write_data,
  output logic [cpu_pkg::data_size-1:0] read_data
);
  import cpu_pkg::*;

  logic [data_size-1:0] mem [2**dmem_size];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 2**dmem_size; i++) begin
        mem[i] <= '0;
      end
    end else if (ctrl.dm_write) begin
      mem[address] <= write_data;
    end
  end

  assign read_data = mem[address];

  // address comes from register contents, so X here means a bad base
  assert property (@(posedge clock) disable iff (reset)
    ctrl.dm_enable |-> !$isunknown(address));

endmodule

//--- hdl/cpu_core.sv
`timescale 1ns/100ps

module cpu_core (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          run,
  input  logic                          load_enable,
  input  logic [cpu_pkg::mem_size-1:0]  load_address,
  input  logic [cpu_pkg::data_size-1:0] load_instr,
  output logic                          commit_valid,
  output cpu_pkg::commit_t              commit
);
  import cpu_pkg::*;

  logic [mem_size-1:0]  pc;
  logic [data_size-1:0] instr;
  logic                 pc_advance;
  logic [mem_size-1:0]  commit_pc;
  fields_t              fields;
  ctrl_t                ctrl;
  logic [data_size-1:0] read_data1;
  logic [data_size-1:0] read_data2;
  logic [data_size-1:0] result;
  logic [dmem_size-1:0] dm_address;
  logic [data_size-1:0] dm_write_data;
  logic [data_size-1:0] dm_read_data;

  fetch_unit fetch0 (
    .clock        (clock),
    .reset        (reset),
    .load_enable  (load_enable),
    .load_address (load_address),
    .load_instr   (load_instr),
    .pc_advance   (pc_advance),
    .pc           (pc),
    .instr        (instr)
  );

  ir_controller ctrl0 (
    .clock        (clock),
    .reset        (reset),
    .run          (run),
    .pc           (pc),
    .instr        (instr),
    .fields       (fields),
    .ctrl         (ctrl),
    .pc_advance   (pc_advance),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc)
  );

  register_file regs0 (
    .clock      (clock),
    .reset      (reset),
    .fields     (fields),
    .ctrl       (ctrl),
    .write_data (result),
    .read_data1 (read_data1),
    .read_data2 (read_data2)
  );

  alu alu0 (
    .fields        (fields),
    .ctrl          (ctrl),
    .read_data1    (read_data1),
    .read_data2    (read_data2),
    .dm_read_data  (dm_read_data),
    .dm_address    (dm_address),
    .dm_write_data (dm_write_data),
    .result        (result)
  );

  data_mem dmem0 (
    .clock      (clock),
    .reset      (reset),
    .ctrl       (ctrl),
    .address    (dm_address),
    .write_data (dm_write_data),
    .read_data  (dm_read_data)
  );

  // commit trace, valid while the controller is in write
  always_comb begin
    commit.pc            = commit_pc;
    commit.reg_write     = ctrl.reg_write;
    commit.write_address = fields.write_address;
    commit.write_data    = result;
    commit.store         = ctrl.dm_write;
    commit.store_address = dm_address;
    commit.store_data    = dm_write_data;
  end

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
  output logic clock,
  output logic reset
);

  // 4 ns period
  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // two full cycles of reset, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

//--- bench/tb_checker.sv
`timescale 1ns/100ps

module tb_checker #(
  parameter int prog_len = 256
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          run,
  input  logic                          load_enable,
  input  logic [cpu_pkg::mem_size-1:0]  load_address,
  input  logic [cpu_pkg::data_size-1:0] load_instr,
  input  logic                          commit_valid,
  input  cpu_pkg::commit_t              commit,
  output logic                          done,
  output int                            value_errors,
  output int                            timing_errors,
  output logic                          timed_out
);
  import cpu_pkg::*;

  // four cycles per instruction plus some slack
  localparam int timeout_limit = 4 * prog_len + 64;

  logic [data_size-1:0] prog [2**mem_size];
  logic [data_size-1:0] model_regs [2**addr_size];
  logic [data_size-1:0] model_mem [2**dmem_size];
  logic [mem_size-1:0]  model_pc;
  int                   run_cycles;
  int                   commits;

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s at pc %h: got %h, expected %h", name, model_pc, got, exp);
      value_errors++;
    end
  endtask

  // steps the model by one instruction and checks the commit against it
  task automatic check_commit();
    logic [31:0] ins;
    logic [4:0]  rt;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [31:0] a;
    logic [31:0] value;
    logic [31:0] ea;
    logic        exp_write;
    logic        exp_store;
    ins       = prog[model_pc];
    rt        = ins[24:20];
    ra        = ins[19:15];
    rb        = ins[14:10];
    a         = model_regs[ra];
    value     = '0;
    ea        = '0;
    exp_write = 1'b1;
    exp_store = 1'b0;
    case (ins[30:25])
      type_basic: begin
        case (ins[4:0])
          op_add:   value = a + model_regs[rb];
          op_sub:   value = a - model_regs[rb];
          op_and:   value = a & model_regs[rb];
          op_or:    value = a | model_regs[rb];
          op_xor:   value = a ^ model_regs[rb];
          op_slli:  value = a << rb;
          op_srli:  value = a >> rb;
          op_rotri: value = (a >> rb) | (a << (32 - int'(rb)));
          default:  value = '0;
        endcase
        // zero shift right is the nop
        if (ins[4:0] == op_srli && rb == 5'd0) begin
          exp_write = 1'b0;
        end
      end
      addi: value = a + {{17{ins[14]}}, ins[14:0]};
      ori:  value = a | {17'd0, ins[14:0]};
      xori: value = a ^ {17'd0, ins[14:0]};
      movi: value = {{12{ins[19]}}, ins[19:0]};
      lwi: begin
        ea    = a + {17'd0, ins[14:0]};
        value = model_mem[ea[dmem_size-1:0]];
      end
      swi: begin
        ea        = a + {17'd0, ins[14:0]};
        exp_write = 1'b0;
        exp_store = 1'b1;
      end
      type_ls: begin
        if (ins[7:0] == ls_sw) begin
          // store data register doubles as the index
          ea        = a + (model_regs[rt] << ins[9:8]);
          exp_write = 1'b0;
          exp_store = 1'b1;
        end else begin
          ea    = a + (model_regs[rb] << ins[9:8]);
          value = model_mem[ea[dmem_size-1:0]];
        end
      end
      default: exp_write = 1'b0;
    endcase

    compare("pc", 32'(commit.pc), 32'(model_pc));
    compare("reg_write", 32'(commit.reg_write), 32'(exp_write));
    compare("store", 32'(commit.store), 32'(exp_store));
    if (exp_write) begin
      compare("write_address", 32'(commit.write_address), 32'(rt));
      compare("write_data", commit.write_data, value);
      model_regs[rt] = value;
    end
    if (exp_store) begin
      compare("store_address", 32'(commit.store_address), 32'(ea[dmem_size-1:0]));
      compare("store_data", commit.store_data, model_regs[rt]);
      model_mem[ea[dmem_size-1:0]] = model_regs[rt];
    end
    model_pc = model_pc + 1'b1;
  endtask

  always @(posedge clock) begin
    // own copy of the program, taken off the load port
    if (load_enable) begin
      prog[load_address] = load_instr;
    end
    if (reset) begin
      done          = 1'b0;
      timed_out     = 1'b0;
      value_errors  = 0;
      timing_errors = 0;
      run_cycles    = 0;
      commits       = 0;
      model_pc      = '0;
      for (int i = 0; i < 2**addr_size; i++) begin
        model_regs[i] = '0;
      end
      for (int i = 0; i < 2**dmem_size; i++) begin
        model_mem[i] = '0;
      end
    end else if (!done) begin
      if (run) begin
        run_cycles++;
      end
      if (commit_valid) begin
        if (!run) begin
          $display("commit at pc %h while run is still low", commit.pc);
          timing_errors++;
        end else if (run_cycles != 4 * (commits + 1)) begin
          $display("commit %0d came %0d cycles after run, expected after %0d cycles",
                   commits, run_cycles, 4 * (commits + 1));
          timing_errors++;
        end
        check_commit();
        commits++;
        if (commits == prog_len) begin
          done = 1'b1;
        end
      end
      if (!done && run_cycles >= timeout_limit) begin
        $display("timeout: only %0d of %0d instructions committed in %0d cycles",
                 commits, prog_len, run_cycles);
        timed_out = 1'b1;
        done      = 1'b1;
      end
    end
  end

endmodule

//--- bench/tb_top.sv
`timescale 1ns/100ps

module tb_top;
  import cpu_pkg::*;

  localparam int prog_len = 256;

  logic                 clock;
  logic                 reset;
  logic                 run;
  logic                 load_enable;
  logic [mem_size-1:0]  load_address;
  logic [data_size-1:0] load_instr;
  logic                 commit_valid;
  commit_t              commit;
  logic                 done;
  int                   value_errors;
  int                   timing_errors;
  logic                 timed_out;
  int                   seed;

  tb_clock clock0 (
    .clock (clock),
    .reset (reset)
  );

  cpu_core dut0 (
    .clock        (clock),
    .reset        (reset),
    .run          (run),
    .load_enable  (load_enable),
    .load_address (load_address),
    .load_instr   (load_instr),
    .commit_valid (commit_valid),
    .commit       (commit)
  );

  tb_checker #(.prog_len(prog_len)) check0 (
    .clock         (clock),
    .reset         (reset),
    .run           (run),
    .load_enable   (load_enable),
    .load_address  (load_address),
    .load_instr    (load_instr),
    .commit_valid  (commit_valid),
    .commit        (commit),
    .done          (done),
    .value_errors  (value_errors),
    .timing_errors (timing_errors),
    .timed_out     (timed_out)
  );

  function automatic int rand_below(int n);
    rand_below = int'($unsigned($random(seed)) % n);
  endfunction

  // one random instruction from the subset
  // r31 holds the memory base, so nothing writes it after the movi prologue
  task automatic make_instr(output logic [31:0] word);
    logic [4:0]  rt;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [14:0] imm;
    rt  = 5'(rand_below(31));
    ra  = 5'(rand_below(32));
    rb  = 5'(rand_below(32));
    imm = 15'($random(seed));
    case (rand_below(17))
      0:  word = {1'b0, type_basic, rt, ra, rb, 5'd0, op_add};
      1:  word = {1'b0, type_basic, rt, ra, rb, 5'd0, op_sub};
      2:  word = {1'b0, type_basic, rt, ra, rb, 5'd0, op_and};
      3:  word = {1'b0, type_basic, rt, ra, rb, 5'd0, op_or};
      4:  word = {1'b0, type_basic, rt, ra, rb, 5'd0, op_xor};
      // shift amount sits where rb would be
      5:  word = {1'b0, type_basic, rt, ra, rb, 5'd0, op_slli};
      6:  word = {1'b0, type_basic, rt, ra, rb, 5'd0, op_srli};
      7:  word = {1'b0, type_basic, rt, ra, rb, 5'd0, op_rotri};
      8:  word = {1'b0, addi, rt, ra, imm};
      9:  word = {1'b0, ori, rt, ra, imm};
      10: word = {1'b0, xori, rt, ra, imm};
      11: word = {1'b0, movi, rt, 20'($random(seed))};
      // small offsets off r31 so loads find earlier stores
      12: word = {1'b0, lwi, rt, 5'd31, 12'd0, imm[2:0]};
      13: word = {1'b0, swi, ra, 5'd31, 12'd0, imm[2:0]};
      14: word = {1'b0, type_ls, rt, 5'd31, rb, imm[1:0], ls_lw};
      15: word = {1'b0, type_ls, ra, 5'd31, rb, imm[1:0], ls_sw};
      default: word = {1'b0, type_basic, 15'd0, 5'd0, op_srli};
    endcase
  endtask

  initial begin
    logic [31:0] word;
    seed         = 32'h22a86259;
    run          = 1'b0;
    load_enable  = 1'b0;
    load_address = '0;
    load_instr   = '0;
    wait (reset === 1'b0);

    // movi to every register first, then random code
    for (int i = 0; i < prog_len; i++) begin
      @(negedge clock);
      if (i < 2**addr_size) begin
        word = {1'b0, movi, 5'(i), 20'($random(seed))};
      end else begin
        make_instr(word);
      end
      load_enable  = 1'b1;
      load_address = mem_size'(i);
      load_instr   = word;
    end
    @(negedge clock);
    load_enable = 1'b0;
    @(negedge clock);
    run = 1'b1;

    wait (done === 1'b1);
    $display("errors: %0d value mismatches, %0d timing, %0d timeout",
             value_errors, timing_errors, timed_out);
    if (value_errors == 0 && timing_errors == 0 && !timed_out) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
common/cpu_pkg.sv
controller/ir_controller.sv
datapath/alu.sv
datapath/register_file.sv
hdl/fetch_unit.sv
hdl/data_mem.sv
hdl/cpu_core.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module tb_top -o sim

output=$(./obj_dir/sim)
echo "$output"

if echo "$output" | grep -qx "Result: PASSED"; then
  exit 0
else
  exit 1
fi
